/* cin_pkg.sv */
package cin_pkg;

    // Link geometry
    // Two lane receivers share one output bus
    localparam int NUM_LANES = 2;
    // Raw nibble width on each lane
    localparam int LANE_W = 4;
    // Assembled command word
    localparam int WORD_W = 32;
    // Nibbles per word, also the framing period in clock cycles
    localparam int NIBBLES_PER_WORD = 8;

    // Training word the lane hunts for after a lock request
    localparam logic [WORD_W-1:0] TRAIN_SEQUENCE = 32'hA55A6996;

    // Lane number carried on the output bus
    typedef logic [$clog2(NUM_LANES)-1:0] lane_id_t;

    // Word from one lane receiver toward the arbiter
    // Valid is a single-cycle strobe, no handshake
    typedef struct packed {
        logic              valid;
        logic [WORD_W-1:0] data;
    } lane_word_t;

    // Word on the merged output bus, tagged with its source lane
    typedef struct packed {
        lane_id_t          lane;
        logic [WORD_W-1:0] data;
    } cin_word_t;

    // Per-lane status levels
    typedef struct packed {
        // Training word found, framing running
        logic locked;
        // Stream not 8-nibble periodic while unlocked
        logic biterr;
    } lane_status_t;

endpackage

/* bit_align.sv */
module bit_align (
    input  logic                       ifclk_i,
    // Clears the bit offset only, lock state lives elsewhere
    input  logic                       rst_bitslip_i,
    // Single-cycle pulse steps the offset by one bit
    input  logic                       slip_i,
    input  logic [cin_pkg::LANE_W-1:0] din_i,
    output logic [cin_pkg::LANE_W-1:0] dout_o
);
    import cin_pkg::*;

    // Previous raw nibble, needed for windows that straddle two nibbles
    logic [LANE_W-1:0]         prev_q;
    // Bit offset into the previous nibble
    logic [$clog2(LANE_W)-1:0] offset_q;
    // Previous and current raw nibbles, MSB first
    logic [2*LANE_W-1:0]       pair;
    logic [LANE_W-1:0]         window;

    assign pair = {prev_q, din_i};

    // Offset 0 passes the previous nibble as is
    // Each step moves the window one bit later in the serial stream
    always_comb begin
        window = pair[(2*LANE_W-1) - offset_q -: LANE_W];
    end

    // Offset wraps modulo the nibble width
    always_ff @(posedge ifclk_i) begin
        if (rst_bitslip_i) begin
            offset_q <= '0;
        end else if (slip_i) begin
            offset_q <= offset_q + 1'b1;
        end
    end

    // Raw nibble history and aligned output
    always_ff @(posedge ifclk_i) begin
        prev_q <= din_i;
        dout_o <= window;
    end

    // Slip pulses must be separated by at least one idle cycle
    // so every offset step is seen by the lock logic downstream
    a_slip_spaced : assert property (
        @(posedge ifclk_i) disable iff (rst_bitslip_i)
        slip_i |=> !slip_i
    ) else $error("bit_align: slip_i high on two consecutive cycles");

endmodule

/* cin_parallel_sync.sv */
module cin_parallel_sync (
    input  logic                       ifclk_i,
    // Clears lock, framing and error state, not the bit offset
    input  logic                       rst_lock_i,
    // Clears the bit offset only
    input  logic                       rst_bitslip_i,
    // Raw, unaligned nibble stream
    input  logic [cin_pkg::LANE_W-1:0] cin_i,
    // Step the aligner one bit
    input  logic                       bitslip_i,
    // Arm the lock on the next training word
    input  logic                       lock_i,
    output cin_pkg::lane_word_t        lane_word_o,
    output cin_pkg::lane_status_t      status_o
);
    import cin_pkg::*;

    localparam int PHASE_W = $clog2(NIBBLES_PER_WORD);

    // Aligned nibble from the bit realigner
    logic [LANE_W-1:0]        cin_align;
    // Seven older nibbles, oldest in the low bits
    logic [WORD_W-LANE_W-1:0] hist_q;
    // Newest nibble on top of the history
    logic [WORD_W-1:0]        cur_word;

    // Lock control
    logic                     lock_en_q;
    logic                     locked_q;
    logic                     match;

    // Framing
    logic [PHASE_W-1:0]       phase_q;
    logic                     cap;
    logic                     cap_q;
    logic                     valid_q;
    // Word waiting for its slot, then the word on the output
    logic [WORD_W-1:0]        word_q;
    logic [WORD_W-1:0]        out_data_q;

    // Unlocked error detection
    logic [LANE_W-1:0]        dly_q [NIBBLES_PER_WORD];
    logic                     biterr_q;

    bit_align u_align (
        .ifclk_i       (ifclk_i),
        .rst_bitslip_i (rst_bitslip_i),
        .slip_i        (bitslip_i),
        .din_i         (cin_i),
        .dout_o        (cin_align)
    );

    assign cur_word = {cin_align, hist_q};

    // Training word seen while armed
    assign match = lock_en_q && (cur_word == TRAIN_SEQUENCE);

    // Last nibble of a word frame
    assign cap = locked_q && (phase_q == PHASE_W'(NIBBLES_PER_WORD - 1));

    // History shift, oldest nibble falls out at the bottom
    always_ff @(posedge ifclk_i) begin
        hist_q <= cur_word[WORD_W-1:LANE_W];
    end

    // Lock arm and acquire
    // Once locked the lane stays locked until rst_lock_i
    always_ff @(posedge ifclk_i) begin
        if (rst_lock_i) begin
            lock_en_q <= 1'b0;
            locked_q  <= 1'b0;
        end else begin
            if (lock_i) begin
                lock_en_q <= 1'b1;
            end
            if (match) begin
                locked_q <= 1'b1;
            end
        end
    end

    // Phase counter runs freely while locked
    // Strobe path is cap, then cap_q, then the valid strobe
    always_ff @(posedge ifclk_i) begin
        if (rst_lock_i || !locked_q) begin
            phase_q <= '0;
        end else begin
            phase_q <= phase_q + 1'b1;
        end

        if (rst_lock_i) begin
            cap_q   <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            cap_q   <= cap;
            valid_q <= cap_q;
        end
    end

    // Training word is taken on the match cycle
    // Later words are taken on each frame end
    // Output data moves one frame behind and settles before the strobe
    always_ff @(posedge ifclk_i) begin
        if ((match && !locked_q) || cap) begin
            word_q <= cur_word;
        end
        if (cap) begin
            out_data_q <= word_q;
        end
    end

    // 8-deep delay of the oldest history nibble
    always_ff @(posedge ifclk_i) begin
        dly_q[0] <= hist_q[LANE_W-1:0];
        for (int i = 1; i < NIBBLES_PER_WORD; i++) begin
            dly_q[i] <= dly_q[i-1];
        end
    end

    // A stream with an 8-nibble period compares equal every cycle
    // Held low once locked
    always_ff @(posedge ifclk_i) begin
        if (rst_lock_i || locked_q) begin
            biterr_q <= 1'b0;
        end else begin
            biterr_q <= (hist_q[LANE_W-1:0] != dly_q[NIBBLES_PER_WORD-1]);
        end
    end

    assign lane_word_o = '{valid: valid_q, data: out_data_q};
    assign status_o    = '{locked: locked_q, biterr: biterr_q};

    // Strobe only while the lane holds lock
    a_valid_locked : assert property (
        @(posedge ifclk_i) disable iff (rst_lock_i)
        valid_q |-> locked_q
    ) else $error("cin_parallel_sync: valid strobe while unlocked");

    // Framing keeps strobes a full word apart
    a_valid_spacing : assert property (
        @(posedge ifclk_i) disable iff (rst_lock_i)
        valid_q |=> !valid_q [*NIBBLES_PER_WORD-1]
    ) else $error("cin_parallel_sync: valid strobes closer than one word");

endmodule

/* cin_word_arbiter.sv */
module cin_word_arbiter (
    input  logic                ifclk_i,
    input  logic                rst_lock_i,
    input  cin_pkg::lane_word_t lane_words_i [cin_pkg::NUM_LANES],
    output cin_pkg::cin_word_t  word_o,
    output logic                word_valid_o,
    // Sticky, a pending word was overwritten
    output logic                overflow_o
);
    import cin_pkg::*;

    // Pending words, one per lane
    logic [NUM_LANES-1:0] pend_v_q;
    logic [WORD_W-1:0]    pend_d_q [NUM_LANES];
    // Lane granted most recently
    lane_id_t             last_q;

    // Incoming strobes and requests
    logic [NUM_LANES-1:0] in_v;
    logic [NUM_LANES-1:0] req;
    logic [WORD_W-1:0]    cand_d [NUM_LANES];
    logic                 any_req;
    lane_id_t             gnt;
    logic [NUM_LANES-1:0] taken;
    logic [NUM_LANES-1:0] pend_v_d;
    logic [NUM_LANES-1:0] ovf_hit;

    // Output registers
    cin_word_t            word_q;
    logic                 word_valid_q;
    logic                 overflow_q;

    // A lane requests with a held word or a fresh strobe
    // Held word is older, so it goes out first
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            in_v[i]   = lane_words_i[i].valid;
            req[i]    = pend_v_q[i] | in_v[i];
            cand_d[i] = pend_v_q[i] ? pend_d_q[i] : lane_words_i[i].data;
        end
        any_req = |req;
    end

    // Round robin, search starts at the lane after the last grant
    // Closest requester wins since it is checked last
    always_comb begin
        int idx;
        gnt = last_q;
        for (int k = NUM_LANES; k >= 1; k--) begin
            idx = (int'(last_q) + k) % NUM_LANES;
            if (req[idx]) begin
                gnt = lane_id_t'(idx);
            end
        end
    end

    // Next pending state per lane
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            taken[i]    = any_req && (gnt == lane_id_t'(i));
            // Granted lane keeps only a strobe that arrived behind a held word
            pend_v_d[i] = taken[i] ? (pend_v_q[i] & in_v[i]) : req[i];
            ovf_hit[i]  = in_v[i] & pend_v_q[i] & ~taken[i];
        end
    end

    // Pending data always takes the newest strobe
    always_ff @(posedge ifclk_i) begin
        for (int i = 0; i < NUM_LANES; i++) begin
            if (in_v[i]) begin
                pend_d_q[i] <= lane_words_i[i].data;
            end
        end
        if (any_req) begin
            word_q.lane <= gnt;
            word_q.data <= cand_d[gnt];
        end
    end

    // Control state
    // Last grant starts on the top lane so lane 0 wins the first tie
    always_ff @(posedge ifclk_i) begin
        if (rst_lock_i) begin
            pend_v_q     <= '0;
            last_q       <= lane_id_t'(NUM_LANES - 1);
            word_valid_q <= 1'b0;
            overflow_q   <= 1'b0;
        end else begin
            pend_v_q     <= pend_v_d;
            word_valid_q <= any_req;
            if (any_req) begin
                last_q <= gnt;
            end
            if (|ovf_hit) begin
                overflow_q <= 1'b1;
            end
        end
    end

    assign word_o       = word_q;
    assign word_valid_o = word_valid_q;
    assign overflow_o   = overflow_q;

    // One word leaves per cycle, so a lane strobe reaches the bus
    // after one cycle alone or two cycles under contention
    for (genvar gi = 0; gi < NUM_LANES; gi++) begin : g_latency
        a_issue_window : assert property (
            @(posedge ifclk_i) disable iff (rst_lock_i)
            in_v[gi] |-> ##[1:2] (word_valid_q && word_q.lane == lane_id_t'(gi))
        ) else $error("cin_word_arbiter: lane %0d word not issued in time", gi);
    end

    // Lane framing keeps strobes apart, so a held word is never lost
    a_no_overflow : assert property (
        @(posedge ifclk_i) disable iff (rst_lock_i)
        !overflow_q
    ) else $error("cin_word_arbiter: pending word overwritten");

endmodule

/* cin_rx_top.sv */
module cin_rx_top (
    input  logic                       ifclk_i,
    input  logic                       rst_lock_i,
    input  logic                       rst_bitslip_i,
    // Raw nibble stream per lane
    input  logic [cin_pkg::LANE_W-1:0] cin_i [cin_pkg::NUM_LANES],
    input  logic [cin_pkg::NUM_LANES-1:0] bitslip_i,
    input  logic [cin_pkg::NUM_LANES-1:0] lock_i,
    output cin_pkg::lane_status_t      status_o [cin_pkg::NUM_LANES],
    // Merged, lane-tagged word bus
    output cin_pkg::cin_word_t         word_o,
    output logic                       word_valid_o,
    output logic                       overflow_o
);
    import cin_pkg::*;

    // Lane receivers to arbiter
    lane_word_t lane_words [NUM_LANES];

    // One receiver per lane, all identical peers
    for (genvar gl = 0; gl < NUM_LANES; gl++) begin : g_lane
        cin_parallel_sync u_sync (
            .ifclk_i       (ifclk_i),
            .rst_lock_i    (rst_lock_i),
            .rst_bitslip_i (rst_bitslip_i),
            .cin_i         (cin_i[gl]),
            .bitslip_i     (bitslip_i[gl]),
            .lock_i        (lock_i[gl]),
            .lane_word_o   (lane_words[gl]),
            .status_o      (status_o[gl])
        );
    end

    // Round-robin merge onto the output bus
    cin_word_arbiter u_arb (
        .ifclk_i      (ifclk_i),
        .rst_lock_i   (rst_lock_i),
        .lane_words_i (lane_words),
        .word_o       (word_o),
        .word_valid_o (word_valid_o),
        .overflow_o   (overflow_o)
    );

endmodule

/* cin_rx_checker.sv */
module cin_rx_checker #(
    parameter int N_DATA    = 150,
    parameter int N_CORRUPT = 6
) (
    input  logic                  ifclk_i,
    input  logic                  rst_lock_i,
    input  cin_pkg::lane_status_t status_i [cin_pkg::NUM_LANES],
    input  cin_pkg::cin_word_t    word_i,
    input  logic                  word_valid_i,
    input  logic                  overflow_i,
    output int                    error_count_o,
    output int                    words_min_o
);
    timeunit 1ns;
    timeprecision 1ps;
    import cin_pkg::*;

    // Expected words per lane, training word at the head
    logic [WORD_W-1:0] exp_q [NUM_LANES][$];
    int                received [NUM_LANES] = '{default: 0};
    int                train_cyc [NUM_LANES] = '{default: 0};
    bit                locked_prev [NUM_LANES] = '{default: 1'b0};
    int                cyc = 0;
    int                errors = 0;
    int                checks = 0;
    int                tests_pass = 0;
    int                tests_fail = 0;
    bit                fail_lock = 1'b0;
    bit                fail_frame = 1'b0;
    bit                fail_arb = 1'b0;
    bit                fail_lockerr = 1'b0;

    assign error_count_o = errors;

    always_comb begin
        words_min_o = received[0];
        for (int l = 1; l < NUM_LANES; l++) begin
            if (received[l] < words_min_o) begin
                words_min_o = received[l];
            end
        end
    end

    function automatic void push_expected(int lane, logic [WORD_W-1:0] w);
        exp_q[lane].push_back(w);
    endfunction

    function automatic void report_test(string name, bit ok);
        $display("Test %-26s : %s", name, ok ? "PASS" : "FAIL");
        if (ok) begin
            tests_pass++;
        end else begin
            tests_fail++;
        end
    endfunction

    // Sampled mid-cycle where all DUT outputs are settled
    always @(negedge ifclk_i) begin : monitor
        logic [WORD_W-1:0] exp_w;
        int                ln;
        int                idx;
        cyc = cyc + 1;
        if (rst_lock_i) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                locked_prev[l] = 1'b0;
            end
        end else begin
            checks++;
            // Overflow flag is sticky
            if (overflow_i !== 1'b0 && !fail_arb) begin
                $display("Overflow flag raised at cycle %0d", cyc);
                errors++;
                fail_arb = 1'b1;
            end
            // First locked cycle may still carry the last unlocked compare
            for (int l = 0; l < NUM_LANES; l++) begin
                if (locked_prev[l] && status_i[l].biterr !== 1'b0) begin
                    $display("Lane %0d biterr high while locked at cycle %0d", l, cyc);
                    errors++;
                    fail_lockerr = 1'b1;
                end
                locked_prev[l] = (status_i[l].locked === 1'b1);
            end
            if (word_valid_i === 1'b1) begin
                ln  = int'(word_i.lane);
                idx = received[ln];
                checks++;
                if (exp_q[ln].size() == 0) begin
                    $display("Extra word on lane %0d with nothing expected", ln);
                    errors++;
                    fail_frame = 1'b1;
                end else begin
                    exp_w = exp_q[ln].pop_front();
                    if (word_i.data !== exp_w) begin
                        $display("MISMATCH word_o.data lane %0d word %0d: got %h expected %h",
                                 ln, idx, word_i.data, exp_w);
                        errors++;
                        if (idx == 0) begin
                            fail_lock = 1'b1;
                        end else if (idx > N_DATA && idx <= N_DATA + N_CORRUPT) begin
                            fail_lockerr = 1'b1;
                        end else begin
                            fail_frame = 1'b1;
                        end
                    end
                end
                if (idx == 0) begin
                    train_cyc[ln] = cyc;
                    if (status_i[ln].locked !== 1'b1) begin
                        $display("Lane %0d training word delivered while not locked", ln);
                        errors++;
                        fail_lock = 1'b1;
                    end
                end
                received[ln] = idx + 1;
            end
        end
    end

    task automatic check_reset_state(int n);
        bit ok;
        ok = 1'b1;
        repeat (n) begin
            @(negedge ifclk_i);
            if (word_valid_i !== 1'b0 || overflow_i !== 1'b0) begin
                ok = 1'b0;
            end
            for (int l = 0; l < NUM_LANES; l++) begin
                if (status_i[l].locked !== 1'b0) begin
                    ok = 1'b0;
                end
            end
        end
        if (!ok) begin
            $display("Valid, overflow or locked not low around reset");
            errors++;
        end
        report_test("reset state", ok);
    endtask

    task automatic check_biterr_quiet(int n);
        bit ok;
        ok = 1'b1;
        repeat (n) begin
            @(negedge ifclk_i);
            for (int l = 0; l < NUM_LANES; l++) begin
                if (status_i[l].biterr !== 1'b0 && ok) begin
                    $display("Lane %0d biterr high on a periodic stream", l);
                    errors++;
                    ok = 1'b0;
                end
            end
        end
        report_test("biterr quiet", ok);
    endtask

    // Flipped lane must flag, the other lane must not
    task automatic check_biterr_rise(int lane, int n);
        bit seen;
        bit other;
        seen  = 1'b0;
        other = 1'b0;
        repeat (n) begin
            @(negedge ifclk_i);
            for (int l = 0; l < NUM_LANES; l++) begin
                if (status_i[l].biterr === 1'b1) begin
                    if (l == lane) begin
                        seen = 1'b1;
                    end else begin
                        other = 1'b1;
                    end
                end
            end
        end
        if (!seen) begin
            $display("Lane %0d biterr never rose after a flipped nibble", lane);
            errors++;
        end
        if (other) begin
            $display("biterr rose on a lane without a flipped nibble");
            errors++;
        end
        report_test("biterr on flipped nibble", seen && !other);
    endtask

    task automatic report_final(int min_words);
        for (int l = 0; l < NUM_LANES; l++) begin
            if (status_i[l].locked !== 1'b1) begin
                $display("Lane %0d not locked at the end of the run", l);
                errors++;
                fail_lock = 1'b1;
            end
            // Lanes run in step, so a lost or extra word leaves one lane off the count
            if (received[l] != min_words) begin
                $display("Lane %0d delivered %0d words, expected %0d", l, received[l], min_words);
                errors++;
                fail_frame = 1'b1;
            end
        end
        report_test("lock acquisition", !fail_lock);
        report_test("data framing", !fail_frame);
        // Lane 0 wins the first tie since the last grant starts on lane 1
        if (received[0] == 0 || received[1] == 0 || train_cyc[1] - train_cyc[0] != 1) begin
            $display("Training words not on consecutive cycles with lane 0 first");
            errors++;
            fail_arb = 1'b1;
        end
        report_test("arbitration", !fail_arb);
        report_test("biterr while locked", !fail_lockerr);
        $display("Tests: %0d passed, %0d failed; checks: %0d; errors: %0d; words: %0d/%0d",
                 tests_pass, tests_fail, checks, errors, received[0], received[1]);
    endtask

endmodule

/* tb_cin_rx.sv */
module tb_cin_rx;
    timeunit 1ns;
    timeprecision 1ps;
    import cin_pkg::*;

    localparam int N_DATA       = 150;
    localparam int N_CORRUPT    = 6;
    // Words each lane delivers after lock, training word first
    localparam int N_WORDS      = 1 + N_DATA + N_CORRUPT;
    localparam int RESET_CYCLES = 10;
    // Locked streaming dominates, pre-lock phases fit in the margin, doubled for slack
    localparam int MAX_CYCLES   = (N_WORDS * NIBBLES_PER_WORD + 200) * 2;

    logic                         ifclk;
    logic                         rst_lock;
    logic                         rst_bitslip;
    logic [LANE_W-1:0]            cin [NUM_LANES] = '{default: '0};
    logic [NUM_LANES-1:0]         bitslip;
    logic [NUM_LANES-1:0]         lock;
    lane_status_t                 status [NUM_LANES];
    cin_word_t                    word;
    logic                         word_valid;
    logic                         overflow;

    int unsigned                  cycle_cnt = 0;
    integer                       seed;
    // Serial bit stream per lane, front is the next bit on the wire
    bit                           bitq [NUM_LANES][$];
    // Idle word that repeats every 8 nibbles before lock
    logic [WORD_W-1:0]            fill_w [NUM_LANES];
    // Bit offset of each lane, also the slip count it needs
    int                           pad_bits [NUM_LANES];
    // After training every word sent is also expected on the bus
    bit                           tracking;
    int                           error_count;
    int                           words_min;

    cin_rx_top dut_i (
        .ifclk_i       (ifclk),
        .rst_lock_i    (rst_lock),
        .rst_bitslip_i (rst_bitslip),
        .cin_i         (cin),
        .bitslip_i     (bitslip),
        .lock_i        (lock),
        .status_o      (status),
        .word_o        (word),
        .word_valid_o  (word_valid),
        .overflow_o    (overflow)
    );

    cin_rx_checker #(
        .N_DATA    (N_DATA),
        .N_CORRUPT (N_CORRUPT)
    ) chk_i (
        .ifclk_i       (ifclk),
        .rst_lock_i    (rst_lock),
        .status_i      (status),
        .word_i        (word),
        .word_valid_i  (word_valid),
        .overflow_i    (overflow),
        .error_count_o (error_count),
        .words_min_o   (words_min)
    );

    initial begin
        ifclk = 1'b0;
        forever #50 ifclk = ~ifclk;
    end

    // Lane history puts the newest nibble on top, so the low nibble goes first
    // Bits inside a nibble go MSB first
    function automatic void append_word(int lane, logic [WORD_W-1:0] w);
        for (int n = 0; n < NIBBLES_PER_WORD; n++) begin
            for (int b = LANE_W - 1; b >= 0; b--) begin
                bitq[lane].push_back(w[n*LANE_W + b]);
            end
        end
    endfunction

    // One nibble at a random position gets a nonzero flip
    function automatic logic [WORD_W-1:0] flip_nibble(logic [WORD_W-1:0] w);
        int                pos;
        logic [LANE_W-1:0] x;
        pos = $random(seed) & 7;
        x   = LANE_W'($random(seed));
        if (x == '0) begin
            x = 1;
        end
        return w ^ (WORD_W'(x) << (pos * LANE_W));
    endfunction

    task automatic wait_cycles(int n);
        repeat (n) @(posedge ifclk);
    endtask

    // Offset starts at zero, so a lane with r pad bits needs r slips
    task automatic slip_lanes();
        for (int i = 0; i < LANE_W; i++) begin
            @(posedge ifclk);
            for (int l = 0; l < NUM_LANES; l++) begin
                bitslip[l] <= (i < pad_bits[l]);
            end
            @(posedge ifclk);
            bitslip <= '0;
        end
    endtask

    // Serializer, regroups each lane's bit stream into raw nibbles
    always @(posedge ifclk) begin : drive_lanes
        logic [WORD_W-1:0] w;
        logic [LANE_W-1:0] nib;
        for (int l = 0; l < NUM_LANES; l++) begin
            if (bitq[l].size() < LANE_W) begin
                if (tracking) begin
                    w = $random(seed);
                    append_word(l, w);
                    chk_i.push_expected(l, w);
                end else begin
                    append_word(l, fill_w[l]);
                end
            end
            for (int b = LANE_W - 1; b >= 0; b--) begin
                nib[b] = bitq[l].pop_front();
            end
            cin[l] <= nib;
        end
    end

    always @(posedge ifclk) begin : watchdog
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Run timed out after %0d cycles", cycle_cnt);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin : main_seq
        logic [WORD_W-1:0] w;
        int                lane_err;
        seed        = 32'h8fc6d91e;
        tracking    = 1'b0;
        rst_lock    = 1'b1;
        rst_bitslip = 1'b1;
        bitslip     = '0;
        lock        = '0;
        for (int l = 0; l < NUM_LANES; l++) begin
            pad_bits[l] = $random(seed) & 3;
            fill_w[l]   = $random(seed);
            for (int p = 0; p < pad_bits[l]; p++) begin
                bitq[l].push_back(1'($random(seed)));
            end
        end

        // Reset state, sampled through reset and a few cycles after
        fork
            begin
                wait_cycles(RESET_CYCLES);
                rst_lock    <= 1'b0;
                rst_bitslip <= 1'b0;
            end
            chk_i.check_reset_state(RESET_CYCLES + 6);
        join

        // Periodic stream first, then one flipped nibble on one lane
        wait_cycles(24);
        chk_i.check_biterr_quiet(40);
        @(negedge ifclk);
        lane_err = $random(seed) & 1;
        for (int l = 0; l < NUM_LANES; l++) begin
            append_word(l, (l == lane_err) ? flip_nibble(fill_w[l]) : fill_w[l]);
        end
        chk_i.check_biterr_rise(lane_err, 30);
        wait_cycles(24);

        // Align, arm the lock, then training word on both lanes at once
        slip_lanes();
        wait_cycles(4);
        @(posedge ifclk);
        lock <= '1;
        @(posedge ifclk);
        lock <= '0;
        @(negedge ifclk);
        tracking = 1'b1;
        for (int l = 0; l < NUM_LANES; l++) begin
            append_word(l, TRAIN_SEQUENCE);
            chk_i.push_expected(l, TRAIN_SEQUENCE);
        end
        for (int i = 0; i < N_DATA; i++) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                w = $random(seed);
                append_word(l, w);
                chk_i.push_expected(l, w);
            end
        end
        // Corrupted words while locked
        for (int i = 0; i < N_CORRUPT; i++) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                w = flip_nibble($random(seed));
                append_word(l, w);
                chk_i.push_expected(l, w);
            end
        end

        while (words_min < N_WORDS) begin
            @(negedge ifclk);
        end
        wait_cycles(4);
        chk_i.report_final(N_WORDS);
        @(negedge ifclk);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* compile.f */
cin_pkg.sv
bit_align.sv
cin_parallel_sync.sv
cin_word_arbiter.sv
cin_rx_top.sv
cin_rx_checker.sv
tb_cin_rx.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_cin_rx
FLIST     ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
